// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vtb_core_mem_subsys: sim.f rtl/*.sv tb/*.sv
	verilator --binary --timing --assert -f sim.f --top-module tb_core_mem_subsys

run: obj_dir/Vtb_core_mem_subsys
	./obj_dir/Vtb_core_mem_subsys | tee sim.log
	grep -q "^Test OK$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module tb_core_mem_subsys

clean:
	rm -rf obj_dir sim.log

// File: rtl/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder
  import core_bus_pkg::*, mem_pkg::*;
(
  input  wire                clk,
  input  wire                core_reset,
  input  wire fetch_cmd_t    fetch,
  input  wire core_cmd_t     dbus,
  input  wire data_dma_req_t data_dma,
  input  wire ins_dma_req_t  ins_dma,
  output logic               mem_sel,
  output logic               desc_rd,
  output logic               desc_wr,
  output core_msg_t          core_msg,
  output logic               core_msg_valid,
  output logic               fetch_err,
  output logic               data_err,
  output logic               fetch_rsp_valid,
  output logic               data_rsp_valid,
  output logic               interrupt
);

  logic io_sel;
  logic io_reserved;
  logic mem_range_err;
  logic desc_dir_err;
  logic data_bad;
  logic dma_range_err;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  assign io_sel        = dbus.addr[IO_SEL_BIT];
  assign io_reserved   = (|dbus.addr[31:ADDR_WIDTH]) ||
                         (|dbus.addr[IO_SEL_BIT-1:IO_OFS_BITS]);
  assign mem_range_err = |dbus.addr[31:DMEM_ADDR_WIDTH];
  // Reads belong to offsets 0 and 4, writes to 8 and 12
  assign desc_dir_err  = dbus.wr != dbus.addr[IO_DIR_BIT];

  assign mem_sel = dbus.valid && !io_sel && !mem_range_err;
  assign desc_rd = dbus.valid && io_sel && !io_reserved && !dbus.wr && !dbus.addr[IO_DIR_BIT];
  assign desc_wr = dbus.valid && io_sel && !io_reserved && dbus.wr && dbus.addr[IO_DIR_BIT];

  assign data_bad = dbus.valid && (io_sel ? (io_reserved || desc_dir_err) : mem_range_err);

  // Stores past the coherent point are broadcast
  assign core_msg.addr  = dbus.addr[ADDR_WIDTH-1:0];
  assign core_msg.data  = dbus.wdata;
  assign core_msg_valid = dbus.valid && dbus.wr && (dbus.addr >= 32'(COHERENT_START));

  assign dma_range_err =
    (data_dma.en && (|data_dma.addr[ADDR_WIDTH-1:DMEM_ADDR_WIDTH])) ||
    ((|ins_dma.wen) && (|ins_dma.addr[ADDR_WIDTH-1:IMEM_ADDR_WIDTH]));

  //////////////////////////////////////////////////////////////////////
  // Response strobes and sticky flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (core_reset) begin
      fetch_rsp_valid <= 1'b0;
      data_rsp_valid  <= 1'b0;
      fetch_err       <= 1'b0;
      data_err        <= 1'b0;
      interrupt       <= 1'b0;
    end else begin
      fetch_rsp_valid <= fetch.valid;
      data_rsp_valid  <= dbus.valid;
      fetch_err       <= fetch_err || (fetch.valid && (|fetch.pc[31:IMEM_ADDR_WIDTH]));
      data_err        <= data_err || data_bad;
      interrupt       <= interrupt || dma_range_err;
    end
  end

  // One descriptor direction per access
  assert property (@(posedge clk) disable iff (core_reset) !(desc_rd && desc_wr))
    else $error("desc_rd and desc_wr together at %h", dbus.addr);

endmodule

`default_nettype wire

// File: rtl/core_bus_pkg.sv
`default_nettype none

package core_bus_pkg;

  localparam int WORD_WIDTH = 32;
  localparam int ADDR_WIDTH = 16;
  localparam logic [ADDR_WIDTH-1:0] COHERENT_START = 16'h6FFF;

  // I/O map. Bit 3 picks the descriptor direction and bit 2 the half
  localparam int IO_SEL_BIT  = 15;
  localparam int IO_DIR_BIT  = 3;
  localparam int IO_HALF_BIT = 2;
  localparam int IO_OFS_BITS = 4;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  typedef struct packed {
    logic                  valid;
    logic                  wr;
    logic [31:0]           addr;
    logic [WORD_WIDTH-1:0] wdata;
    size_e                 size;
  } core_cmd_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } fetch_cmd_t;

  typedef struct packed {
    logic                  valid;
    logic                  error;
    logic [WORD_WIDTH-1:0] rdata;
  } core_rsp_t;

  // Descriptor seen whole by the network side and as two words by the core
  typedef union packed {
    logic [63:0]                whole;
    logic [1:0][WORD_WIDTH-1:0] half;
  } desc_u;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [WORD_WIDTH-1:0] data;
  } core_msg_t;

endpackage

`default_nettype wire

// File: rtl/core_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_subsys
  import core_bus_pkg::*, mem_pkg::*;
(
  input  wire                   clk,
  input  wire                   core_reset,
  input  wire fetch_cmd_t       fetch,
  output core_rsp_t             fetch_rsp,
  input  wire core_cmd_t        dbus,
  output core_rsp_t             dbus_rsp,
  input  wire data_dma_req_t    data_dma,
  output logic [LINE_WIDTH-1:0] data_dma_rd_data,
  input  wire ins_dma_req_t     ins_dma,
  input  wire desc_u            in_desc,
  input  wire                   in_desc_valid,
  output logic                  in_desc_taken,
  output desc_u                 out_desc,
  output logic                  out_desc_valid,
  input  wire                   out_desc_taken,
  output core_msg_t             core_msg,
  output logic                  core_msg_valid,
  output logic                  interrupt
);

  logic                      mem_sel;
  logic                      desc_rd;
  logic                      desc_wr;
  logic                      fetch_err;
  logic                      data_err;
  logic                      fetch_rsp_valid;
  logic                      data_rsp_valid;
  line_req_t                 dmem_req;
  logic [LINE_WIDTH-1:0]     dmem_rdata;
  logic                      imem_en;
  logic [IMEM_LINE_BITS-1:0] imem_line;
  logic [LINE_WIDTH-1:0]     imem_rdata;
  logic [WORD_WIDTH-1:0]     desc_rd_word;
  logic                      desc_rd_last;
  logic [WORD_WIDTH-1:0]     data_rdata;
  logic [WORD_WIDTH-1:0]     fetch_rdata;
  logic [3:0]                word_mask;

  assign fetch_rsp = '{valid: fetch_rsp_valid, error: fetch_err, rdata: fetch_rdata};
  assign dbus_rsp  = '{valid: data_rsp_valid, error: data_err, rdata: data_rdata};

  //////////////////////////////////////////////////////////////////////
  // Decode and word to line conversion
  //////////////////////////////////////////////////////////////////////

  bus_decoder i_bus_decoder (
    .clk             (clk),
    .core_reset      (core_reset),
    .fetch           (fetch),
    .dbus            (dbus),
    .data_dma        (data_dma),
    .ins_dma         (ins_dma),
    .mem_sel         (mem_sel),
    .desc_rd         (desc_rd),
    .desc_wr         (desc_wr),
    .core_msg        (core_msg),
    .core_msg_valid  (core_msg_valid),
    .fetch_err       (fetch_err),
    .data_err        (data_err),
    .fetch_rsp_valid (fetch_rsp_valid),
    .data_rsp_valid  (data_rsp_valid),
    .interrupt       (interrupt)
  );

  word_lane_adapter i_word_lane_adapter (
    .clk          (clk),
    .dbus         (dbus),
    .mem_sel      (mem_sel),
    .fetch        (fetch),
    .dmem_req     (dmem_req),
    .dmem_rdata   (dmem_rdata),
    .imem_en      (imem_en),
    .imem_line    (imem_line),
    .imem_rdata   (imem_rdata),
    .desc_rd_word (desc_rd_word),
    .desc_rd_last (desc_rd_last),
    .data_rdata   (data_rdata),
    .fetch_rdata  (fetch_rdata),
    .word_mask    (word_mask)
  );

  desc_mailbox i_desc_mailbox (
    .clk            (clk),
    .core_reset     (core_reset),
    .desc_rd        (desc_rd),
    .desc_wr        (desc_wr),
    .hi_sel         (dbus.addr[IO_HALF_BIT]),
    .word_mask      (word_mask),
    .wdata          (dbus.wdata),
    .in_desc        (in_desc),
    .in_desc_valid  (in_desc_valid),
    .in_desc_taken  (in_desc_taken),
    .out_desc       (out_desc),
    .out_desc_valid (out_desc_valid),
    .out_desc_taken (out_desc_taken),
    .rd_word        (desc_rd_word),
    .rd_last        (desc_rd_last)
  );

  //////////////////////////////////////////////////////////////////////
  // Memories
  //////////////////////////////////////////////////////////////////////

  // Port A serves the core, port B the DMA engine
  line_ram_2rw #(
    .DEPTH_BITS (DMEM_LINE_BITS)
  ) i_dmem (
    .clk     (clk),
    .a_en    (dmem_req.en),
    .a_wen   (dmem_req.wen),
    .a_addr  (dmem_req.line_idx),
    .a_wdata (dmem_req.wdata),
    .a_rdata (dmem_rdata),
    .b_en    (data_dma.en),
    .b_ren   (data_dma.ren),
    .b_wen   (data_dma.wen),
    .b_addr  (data_dma.addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS]),
    .b_wdata (data_dma.wdata),
    .b_rdata (data_dma_rd_data)
  );

  line_ram_1r1w #(
    .DEPTH_BITS (IMEM_LINE_BITS)
  ) i_imem (
    .clk     (clk),
    .w_wen   (ins_dma.wen),
    .w_addr  (ins_dma.addr[IMEM_ADDR_WIDTH-1:LINE_ADDR_BITS]),
    .w_wdata (ins_dma.wdata),
    .r_en    (imem_en),
    .r_addr  (imem_line),
    .r_rdata (imem_rdata)
  );

endmodule

`default_nettype wire

// File: rtl/desc_mailbox.sv
`timescale 1ns/1ps
`default_nettype none

module desc_mailbox
  import core_bus_pkg::*;
(
  input  wire                   clk,
  input  wire                   core_reset,
  input  wire                   desc_rd,
  input  wire                   desc_wr,
  input  wire                   hi_sel,
  input  wire  [3:0]            word_mask,
  input  wire  [WORD_WIDTH-1:0] wdata,
  input  wire  desc_u           in_desc,
  input  wire                   in_desc_valid,
  output logic                  in_desc_taken,
  output desc_u                 out_desc,
  output logic                  out_desc_valid,
  input  wire                   out_desc_taken,
  output logic [WORD_WIDTH-1:0] rd_word,
  output logic                  rd_last
);

  logic [1:0] out_half_v;
  logic [1:0] in_half_rd;

  //////////////////////////////////////////////////////////////////////
  // Outgoing descriptor
  //////////////////////////////////////////////////////////////////////

  // Byte writable, later writes overwrite while not taken
  always_ff @(posedge clk) begin
    if (desc_wr) begin
      for (int i = 0; i < 4; i++) begin
        if (word_mask[i]) begin
          out_desc.half[hi_sel][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (core_reset) begin
      out_half_v <= '0;
    end else if (out_desc_valid && out_desc_taken) begin
      out_half_v <= '0;
    end else if (desc_wr) begin
      out_half_v[hi_sel] <= 1'b1;
    end
  end

  assign out_desc_valid = &out_half_v;

  //////////////////////////////////////////////////////////////////////
  // Incoming descriptor
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (core_reset) begin
      in_half_rd <= '0;
      rd_last    <= 1'b0;
    end else begin
      rd_last <= desc_rd;
      if (in_desc_taken && in_desc_valid) begin
        in_half_rd <= '0;
      end else if (desc_rd) begin
        // Nothing to read drops any half already seen
        if (in_desc_valid) begin
          in_half_rd[hi_sel] <= 1'b1;
        end else begin
          in_half_rd <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (desc_rd) begin
      rd_word <= in_desc_valid ? in_desc.half[hi_sel] : '0;
    end
  end

  assign in_desc_taken = &in_half_rd;

  // Posted descriptor is held until the consumer takes it
  assert property (@(posedge clk) disable iff (core_reset)
    out_desc_valid && !out_desc_taken |=> out_desc_valid)
    else $error("out_desc_valid dropped without out_desc_taken, out_desc %h",
                $past(out_desc.whole));

endmodule

`default_nettype wire

// File: rtl/line_ram_1r1w.sv
`timescale 1ns/1ps
`default_nettype none

module line_ram_1r1w
  import mem_pkg::*;
#(
  parameter int DEPTH_BITS = 10
) (
  input  wire                   clk,
  input  wire  [STRB_WIDTH-1:0] w_wen,
  input  wire  [DEPTH_BITS-1:0] w_addr,
  input  wire  [LINE_WIDTH-1:0] w_wdata,
  input  wire                   r_en,
  input  wire  [DEPTH_BITS-1:0] r_addr,
  output logic [LINE_WIDTH-1:0] r_rdata
);

  logic [LINE_WIDTH-1:0] mem [2**DEPTH_BITS];

  // Loaded by DMA only
  always_ff @(posedge clk) begin
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (w_wen[i]) begin
        mem[w_addr][i*8 +: 8] <= w_wdata[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (r_en) begin
      r_rdata <= mem[r_addr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/line_ram_2rw.sv
`timescale 1ns/1ps
`default_nettype none

module line_ram_2rw
  import mem_pkg::*;
#(
  parameter int DEPTH_BITS = 12
) (
  input  wire                   clk,
  input  wire                   a_en,
  input  wire  [STRB_WIDTH-1:0] a_wen,
  input  wire  [DEPTH_BITS-1:0] a_addr,
  input  wire  [LINE_WIDTH-1:0] a_wdata,
  output logic [LINE_WIDTH-1:0] a_rdata,
  input  wire                   b_en,
  input  wire                   b_ren,
  input  wire  [STRB_WIDTH-1:0] b_wen,
  input  wire  [DEPTH_BITS-1:0] b_addr,
  input  wire  [LINE_WIDTH-1:0] b_wdata,
  output logic [LINE_WIDTH-1:0] b_rdata
);

  logic [LINE_WIDTH-1:0] mem [2**DEPTH_BITS];
  logic                  a_rd;
  logic                  b_rd;

  // Enable without any strobe is a read
  assign a_rd = a_en && (a_wen == '0);
  assign b_rd = b_en && (b_ren || (b_wen == '0));

  // DMA on port B wins a same-line byte collision
  always_ff @(posedge clk) begin
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (a_en && a_wen[i]) begin
        mem[a_addr][i*8 +: 8] <= a_wdata[i*8 +: 8];
      end
      if (b_en && b_wen[i]) begin
        mem[b_addr][i*8 +: 8] <= b_wdata[i*8 +: 8];
      end
    end
    if (a_rd) begin
      a_rdata <= mem[a_addr];
    end
    if (b_rd) begin
      b_rdata <= mem[b_addr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;
  import core_bus_pkg::*;

  localparam int LINE_WIDTH      = 64;
  localparam int STRB_WIDTH      = LINE_WIDTH / 8;
  localparam int LINE_ADDR_BITS  = $clog2(STRB_WIDTH);
  localparam int IMEM_ADDR_WIDTH = 13;
  localparam int DMEM_ADDR_WIDTH = 15;

  // Line index widths and the number of bits that pick a 32-bit lane
  localparam int IMEM_LINE_BITS = IMEM_ADDR_WIDTH - LINE_ADDR_BITS;
  localparam int DMEM_LINE_BITS = DMEM_ADDR_WIDTH - LINE_ADDR_BITS;
  localparam int LANE_BITS      = LINE_ADDR_BITS - 2;

  typedef struct packed {
    logic                  en;
    logic                  ren;
    logic [STRB_WIDTH-1:0] wen;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LINE_WIDTH-1:0] wdata;
  } data_dma_req_t;

  typedef struct packed {
    logic [STRB_WIDTH-1:0] wen;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LINE_WIDTH-1:0] wdata;
  } ins_dma_req_t;

  typedef struct packed {
    logic                      en;
    logic [STRB_WIDTH-1:0]     wen;
    logic [DMEM_LINE_BITS-1:0] line_idx;
    logic [LINE_WIDTH-1:0]     wdata;
  } line_req_t;

endpackage

`default_nettype wire

// File: rtl/word_lane_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module word_lane_adapter
  import core_bus_pkg::*, mem_pkg::*;
(
  input  wire                       clk,
  input  wire  core_cmd_t           dbus,
  input  wire                       mem_sel,
  input  wire  fetch_cmd_t          fetch,
  output line_req_t                 dmem_req,
  input  wire  [LINE_WIDTH-1:0]     dmem_rdata,
  output logic                      imem_en,
  output logic [IMEM_LINE_BITS-1:0] imem_line,
  input  wire  [LINE_WIDTH-1:0]     imem_rdata,
  input  wire  [WORD_WIDTH-1:0]     desc_rd_word,
  input  wire                       desc_rd_last,
  output logic [WORD_WIDTH-1:0]     data_rdata,
  output logic [WORD_WIDTH-1:0]     fetch_rdata,
  output logic [3:0]                word_mask
);

  logic [LANE_BITS-1:0]  data_lane;
  logic [LANE_BITS-1:0]  data_lane_q;
  logic [LANE_BITS-1:0]  fetch_lane_q;
  logic [STRB_WIDTH-1:0] line_mask;

  assign data_lane = dbus.addr[LINE_ADDR_BITS-1:2];

  // Byte mask inside the 32-bit word
  always_comb begin
    case (dbus.size)
      SIZE_BYTE: word_mask = 4'b0001 << dbus.addr[1:0];
      SIZE_HALF: word_mask = 4'b0011 << dbus.addr[1:0];
      default:   word_mask = 4'b1111;
    endcase
  end

  assign line_mask = {{(STRB_WIDTH-4){1'b0}}, word_mask} << {data_lane, 2'b00};

  // Store data arrives on its byte lanes, only the word lane moves
  always_comb begin
    dmem_req.en       = mem_sel;
    dmem_req.wen      = dbus.wr ? line_mask : '0;
    dmem_req.line_idx = dbus.addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS];
    dmem_req.wdata    = LINE_WIDTH'(dbus.wdata) << {data_lane, 5'b00000};
  end

  assign imem_en   = fetch.valid;
  assign imem_line = fetch.pc[IMEM_ADDR_WIDTH-1:LINE_ADDR_BITS];

  // Lanes held for the read data of the next cycle
  always_ff @(posedge clk) begin
    data_lane_q  <= data_lane;
    fetch_lane_q <= fetch.pc[LINE_ADDR_BITS-1:2];
  end

  assign data_rdata = desc_rd_last ? desc_rd_word
                                   : dmem_rdata[data_lane_q*WORD_WIDTH +: WORD_WIDTH];
  assign fetch_rdata = imem_rdata[fetch_lane_q*WORD_WIDTH +: WORD_WIDTH];

  // Core never issues a half-word that straddles two bytes pairs
  assert property (@(posedge clk) dbus.valid && (dbus.size == SIZE_HALF) |-> !dbus.addr[0])
    else $error("misaligned half-word access at %h", dbus.addr);

endmodule

`default_nettype wire

// File: sim.f
rtl/core_bus_pkg.sv
rtl/mem_pkg.sv
rtl/line_ram_2rw.sv
rtl/line_ram_1r1w.sv
rtl/word_lane_adapter.sv
rtl/desc_mailbox.sv
rtl/bus_decoder.sv
rtl/core_mem_subsys.sv
tb/tb_core_mem_subsys.sv

// File: tb/tb_core_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_mem_subsys
  import core_bus_pkg::*, mem_pkg::*;
();

  localparam int CYCLE_LIMIT = 2000;

  logic            clk = 1'b0;
  logic            core_reset;
  fetch_cmd_t      fetch;
  core_rsp_t       fetch_rsp;
  core_cmd_t       dbus;
  core_rsp_t       dbus_rsp;
  data_dma_req_t   data_dma;
  logic [63:0]     data_dma_rd_data;
  ins_dma_req_t    ins_dma;
  desc_u           in_desc;
  logic            in_desc_valid;
  logic            in_desc_taken;
  desc_u           out_desc;
  logic            out_desc_valid;
  logic            out_desc_taken;
  core_msg_t       core_msg;
  logic            core_msg_valid;
  logic            interrupt;

  // Byte models of both memories
  logic [7:0]  imem_model [0:8191];
  logic [7:0]  dmem_model [0:32767];

  // Expected responses, set with the command and delayed one cycle for the check
  logic        fetch_chk = 1'b0;
  logic        fetch_chk_q = 1'b0;
  logic [31:0] exp_fetch;
  logic [31:0] exp_fetch_q;
  logic        data_chk = 1'b0;
  logic        data_chk_q = 1'b0;
  logic [31:0] exp_data;
  logic [31:0] exp_data_q;
  logic        dma_chk = 1'b0;
  logic        dma_chk_q = 1'b0;
  logic [63:0] exp_dma;
  logic [63:0] exp_dma_q;
  logic        exp_msg_valid = 1'b0;
  core_msg_t   exp_msg;
  logic        exp_out_valid = 1'b0;
  logic [63:0] exp_desc;
  logic        exp_in_taken = 1'b0;
  logic        exp_fetch_err = 1'b0;
  logic        exp_data_err = 1'b0;
  logic        exp_int = 1'b0;

  int value_errs = 0;
  int other_errs = 0;
  int cycles = 0;
  int seed = 32'hac7d;

  core_mem_subsys i_dut (
    .clk              (clk),
    .core_reset       (core_reset),
    .fetch            (fetch),
    .fetch_rsp        (fetch_rsp),
    .dbus             (dbus),
    .dbus_rsp         (dbus_rsp),
    .data_dma         (data_dma),
    .data_dma_rd_data (data_dma_rd_data),
    .ins_dma          (ins_dma),
    .in_desc          (in_desc),
    .in_desc_valid    (in_desc_valid),
    .in_desc_taken    (in_desc_taken),
    .out_desc         (out_desc),
    .out_desc_valid   (out_desc_valid),
    .out_desc_taken   (out_desc_taken),
    .core_msg         (core_msg),
    .core_msg_valid   (core_msg_valid),
    .interrupt        (interrupt)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    fetch_chk_q <= fetch.valid && fetch_chk;
    exp_fetch_q <= exp_fetch;
    data_chk_q  <= dbus.valid && data_chk;
    exp_data_q  <= exp_data;
    dma_chk_q   <= data_dma.en && dma_chk;
    exp_dma_q   <= exp_dma;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the sequence did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (core_reset)
    fetch_rsp.valid == $past(fetch.valid))
    else begin
      other_errs++;
      $display("fetch response strobe did not come exactly one cycle after the fetch");
    end

  assert property (@(posedge clk) disable iff (core_reset)
    dbus_rsp.valid == $past(dbus.valid))
    else begin
      other_errs++;
      $display("data response strobe did not come exactly one cycle after the access");
    end

  assert property (@(posedge clk) disable iff (core_reset)
    fetch_chk_q |-> fetch_rsp.rdata === exp_fetch_q)
    else begin
      value_errs++;
      $display("ERROR fetch_rsp.rdata got %h expected %h",
               $sampled(fetch_rsp.rdata), $sampled(exp_fetch_q));
    end

  assert property (@(posedge clk) disable iff (core_reset)
    data_chk_q |-> dbus_rsp.rdata === exp_data_q)
    else begin
      value_errs++;
      $display("ERROR dbus_rsp.rdata got %h expected %h",
               $sampled(dbus_rsp.rdata), $sampled(exp_data_q));
    end

  assert property (@(posedge clk) disable iff (core_reset)
    dma_chk_q |-> data_dma_rd_data === exp_dma_q)
    else begin
      value_errs++;
      $display("ERROR data_dma_rd_data got %h expected %h",
               $sampled(data_dma_rd_data), $sampled(exp_dma_q));
    end

  assert property (@(posedge clk) disable iff (core_reset)
    core_msg_valid === exp_msg_valid)
    else begin
      value_errs++;
      $display("ERROR core_msg_valid got %h expected %h",
               $sampled(core_msg_valid), $sampled(exp_msg_valid));
    end

  assert property (@(posedge clk) disable iff (core_reset)
    exp_msg_valid |-> core_msg === exp_msg)
    else begin
      value_errs++;
      $display("ERROR core_msg got %h expected %h", $sampled(core_msg), $sampled(exp_msg));
    end

  assert property (@(posedge clk) disable iff (core_reset)
    out_desc_valid === exp_out_valid)
    else begin
      value_errs++;
      $display("ERROR out_desc_valid got %h expected %h",
               $sampled(out_desc_valid), $sampled(exp_out_valid));
    end

  assert property (@(posedge clk) disable iff (core_reset)
    out_desc_valid |-> out_desc.whole === exp_desc)
    else begin
      value_errs++;
      $display("ERROR out_desc got %h expected %h",
               $sampled(out_desc.whole), $sampled(exp_desc));
    end

  assert property (@(posedge clk) disable iff (core_reset)
    in_desc_taken === exp_in_taken)
    else begin
      value_errs++;
      $display("ERROR in_desc_taken got %h expected %h",
               $sampled(in_desc_taken), $sampled(exp_in_taken));
    end

  assert property (@(posedge clk) disable iff (core_reset)
    fetch_rsp.error === exp_fetch_err && dbus_rsp.error === exp_data_err)
    else begin
      value_errs++;
      $display("ERROR fetch_rsp.error/dbus_rsp.error got %h/%h expected %h/%h",
               $sampled(fetch_rsp.error), $sampled(dbus_rsp.error),
               $sampled(exp_fetch_err), $sampled(exp_data_err));
    end

  assert property (@(posedge clk) disable iff (core_reset) interrupt === exp_int)
    else begin
      value_errs++;
      $display("ERROR interrupt got %h expected %h", $sampled(interrupt), $sampled(exp_int));
    end

  //////////////////////////////////////////////////////////////////////
  // Model access and bus tasks
  //////////////////////////////////////////////////////////////////////

  // Little endian word and line from the byte models
  function automatic logic [31:0] imem_word(input logic [15:0] addr);
    int base;
    base = {addr[12:2], 2'b00};
    return {imem_model[base+3], imem_model[base+2], imem_model[base+1], imem_model[base]};
  endfunction

  function automatic logic [31:0] dmem_word(input logic [15:0] addr);
    int base;
    base = {addr[14:2], 2'b00};
    return {dmem_model[base+3], dmem_model[base+2], dmem_model[base+1], dmem_model[base]};
  endfunction

  function automatic logic [63:0] dmem_line(input logic [15:0] addr);
    return {dmem_word({addr[15:3], 3'b100}), dmem_word({addr[15:3], 3'b000})};
  endfunction

  task automatic imem_dma_write(input logic [15:0] addr, input logic [63:0] line);
    @(negedge clk);
    ins_dma = '{wen: 8'hff, addr: addr, wdata: line};
    @(negedge clk);
    ins_dma.wen = '0;
    for (int i = 0; i < 8; i++) begin
      imem_model[{addr[12:3], 3'b000} + i] = line[i*8 +: 8];
    end
  endtask

  task automatic fetch_word(input logic [31:0] pc, input logic check);
    @(negedge clk);
    fetch = '{valid: 1'b1, pc: pc};
    fetch_chk = check;
    exp_fetch = imem_word(pc[15:0]);
    @(negedge clk);
    fetch.valid = 1'b0;
    fetch_chk = 1'b0;
  endtask

  task automatic dma_write(input logic [15:0] addr, input logic [63:0] line);
    @(negedge clk);
    data_dma = '{en: 1'b1, ren: 1'b0, wen: 8'hff, addr: addr, wdata: line};
    @(negedge clk);
    data_dma.en = 1'b0;
    data_dma.wen = '0;
    for (int i = 0; i < 8; i++) begin
      dmem_model[{addr[14:3], 3'b000} + i] = line[i*8 +: 8];
    end
  endtask

  task automatic dma_read(input logic [15:0] addr, input logic check);
    @(negedge clk);
    data_dma = '{en: 1'b1, ren: 1'b1, wen: 8'h00, addr: addr, wdata: '0};
    dma_chk = check;
    exp_dma = dmem_line(addr);
    @(negedge clk);
    data_dma.en = 1'b0;
    data_dma.ren = 1'b0;
    dma_chk = 1'b0;
  endtask

  // Store data sits on its own byte lanes, as the core drives it
  task automatic core_store(input logic [31:0] addr, input logic [31:0] data,
                            input size_e size);
    logic [3:0] mask;
    mask = (size == SIZE_BYTE) ? 4'b0001 << addr[1:0] :
           (size == SIZE_HALF) ? 4'b0011 << addr[1:0] : 4'b1111;
    @(negedge clk);
    dbus = '{valid: 1'b1, wr: 1'b1, addr: addr, wdata: data, size: size};
    exp_msg_valid = addr >= 32'(COHERENT_START);
    exp_msg = '{addr: addr[15:0], data: data};
    @(negedge clk);
    dbus.valid = 1'b0;
    exp_msg_valid = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (mask[i] && addr[IO_SEL_BIT]) begin
        exp_desc[addr[2]*32 + i*8 +: 8] = data[i*8 +: 8];
      end else if (mask[i]) begin
        dmem_model[{addr[14:2], 2'b00} + i] = data[i*8 +: 8];
      end
    end
  endtask

  task automatic core_load(input logic [31:0] addr, input logic check,
                           input logic [31:0] expected);
    @(negedge clk);
    dbus = '{valid: 1'b1, wr: 1'b0, addr: addr, wdata: '0, size: SIZE_WORD};
    data_chk = check;
    exp_data = expected;
    @(negedge clk);
    dbus.valid = 1'b0;
    data_chk = 1'b0;
  endtask

  task automatic take_out_desc;
    @(negedge clk);
    out_desc_taken = 1'b1;
    @(negedge clk);
    out_desc_taken = 1'b0;
    exp_out_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [15:0] ilines [6];
    logic [15:0] dlines [8];
    fetch = '0;
    dbus = '0;
    data_dma = '0;
    ins_dma = '0;
    in_desc = '0;
    in_desc_valid = 1'b0;
    out_desc_taken = 1'b0;
    core_reset = 1'b1;
    repeat (2) @(negedge clk);
    core_reset = 1'b0;

    // Fetch path, both lanes of each line
    for (int i = 0; i < 6; i++) begin
      ilines[i] = 16'($random(seed)) & 16'h1ff8;
      imem_dma_write(ilines[i], {$random(seed), $random(seed)});
    end
    for (int i = 0; i < 6; i++) begin
      fetch_word({16'h0, ilines[i]}, 1'b1);
      fetch_word({16'h0, ilines[i] | 16'h4}, 1'b1);
    end

    // Data path: DMA fill, core stores, DMA readback, then core loads
    for (int i = 0; i < 8; i++) begin
      dlines[i] = 16'($random(seed)) & 16'h6ff8;
      dma_write(dlines[i], {$random(seed), $random(seed)});
    end
    for (int i = 0; i < 8; i++) begin
      core_store({16'h0, dlines[i] | (16'($random(seed)) & 16'h7)}, $random(seed), SIZE_BYTE);
      core_store({16'h0, dlines[i] | (16'($random(seed)) & 16'h6)}, $random(seed), SIZE_HALF);
      core_store({16'h0, dlines[i] | (16'($random(seed)) & 16'h4)}, $random(seed), SIZE_WORD);
    end
    for (int i = 0; i < 8; i++) begin
      dma_read(dlines[i], 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      dma_write(dlines[i], {$random(seed), $random(seed)});
      core_load({16'h0, dlines[i]}, 1'b1, dmem_word(dlines[i]));
      core_load({16'h0, dlines[i] | 16'h4}, 1'b1, dmem_word(dlines[i] | 16'h4));
    end

    // Coherent stores broadcast, loads stay quiet
    core_store(32'h7000, $random(seed), SIZE_WORD);
    core_store(32'h6fff, $random(seed), SIZE_BYTE);
    core_load(32'h7000, 1'b1, dmem_word(16'h7000));
    core_load(32'h6ffc, 1'b1, dmem_word(16'h6ffc));

    // Outgoing descriptor, low half first with words
    core_store(32'h8008, $random(seed), SIZE_WORD);
    repeat (2) @(negedge clk);
    core_store(32'h800c, $random(seed), SIZE_WORD);
    exp_out_valid = 1'b1;
    repeat (2) @(negedge clk);
    take_out_desc();

    // High half first, then the low half byte by byte
    core_store(32'h800c, $random(seed), SIZE_WORD);
    for (int i = 0; i < 4; i++) begin
      core_store(32'h8008 + i, $random(seed), SIZE_BYTE);
      exp_out_valid = 1'b1;
    end
    take_out_desc();

    // Incoming descriptor
    @(negedge clk);
    in_desc.whole = {$random(seed), $random(seed)};
    in_desc_valid = 1'b1;
    core_load(32'h8000, 1'b1, in_desc.half[0]);
    core_load(32'h8004, 1'b1, in_desc.half[1]);
    exp_in_taken = 1'b1;
    @(negedge clk);
    exp_in_taken = 1'b0;
    in_desc_valid = 1'b0;
    core_load(32'h8000, 1'b1, 32'h0);

    // Sticky errors and the DMA interrupt
    core_load(32'h8008, 1'b0, 32'h0);
    exp_data_err = 1'b1;
    fetch_word(32'h2000, 1'b0);
    exp_fetch_err = 1'b1;
    dma_read(16'h8000, 1'b0);
    exp_int = 1'b1;
    repeat (4) @(negedge clk);

    core_reset = 1'b1;
    repeat (2) @(negedge clk);
    exp_data_err = 1'b0;
    exp_fetch_err = 1'b0;
    exp_int = 1'b0;
    core_reset = 1'b0;
    repeat (4) @(negedge clk);

    $display("Checks done: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
